/* source/fetch_pkg.sv */
/*
 * fetch package
 * widths, cache geometry and reset pc shared by the fetch unit and the instruction cache
 */
package fetch_pkg;

    // address and pc width
    localparam int XLEN = 64;

    // instruction width handed to decode
    localparam int ILEN = 32;

    // width of one cache read towards the fetch unit
    localparam int WORD_BITS = 64;

    // width of a cache line and of one memory beat
    localparam int LINE_BITS = 128;

    // byte offset inside a 16-byte line
    localparam int OFFSET_BITS = 4;

    // 64 lines in the direct-mapped store
    localparam int INDEX_BITS = 6;
    localparam int NUM_LINES = 2 ** INDEX_BITS;

    // everything above index and offset
    localparam int TAG_BITS = XLEN - INDEX_BITS - OFFSET_BITS;

    // address bit picking the 64-bit word inside a line
    localparam int WORD_SEL_BIT = 3;

    // address bit picking the 32-bit instruction inside a word
    localparam int INSTR_SEL_BIT = 2;

    // first pc after reset
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

endpackage

/* source/icache.sv */
/*
 * instruction cache
 * direct-mapped, read-only and blocking, 128-bit lines refilled from memory
 * over a valid/ready pair; flush invalidates every line in one cycle
 */
`timescale 1ns/1ps

module icache
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 flush_i,

    // fetch unit side
    input  logic [XLEN-1:0]      cpu_addr_i,
    input  logic                 cpu_req_valid_i,
    output logic [WORD_BITS-1:0] cpu_rdata_o,
    output logic                 cpu_ready_o,
    output logic                 cache_idle_o,

    // memory side
    output logic [XLEN-1:0]      mem_addr_o,
    output logic                 mem_valid_o,
    input  logic [LINE_BITS-1:0] mem_rdata_i,
    input  logic                 mem_ready_i
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } state_t;

    state_t state_q;
    state_t state_d;

    // latched request address
    logic [XLEN-1:0]       addr_q;
    logic [TAG_BITS-1:0]   addr_tag;
    logic [INDEX_BITS-1:0] addr_idx;

    // line store
    logic [LINE_BITS-1:0] data_mem [NUM_LINES];
    logic [TAG_BITS-1:0]  tag_mem  [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    // line returned by memory is written to the store one cycle later
    logic [LINE_BITS-1:0] refill_q;

    logic                 hit;
    logic                 line_wr;
    logic [LINE_BITS-1:0] line_rd;

    assign addr_tag = addr_q[XLEN-1 -: TAG_BITS];
    assign addr_idx = addr_q[OFFSET_BITS +: INDEX_BITS];

    assign line_rd = data_mem[addr_idx];
    assign hit     = valid_q[addr_idx] && (tag_mem[addr_idx] == addr_tag);
    assign line_wr = (state_q == REFILL);

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cpu_req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                // a miss raises mem_valid_o right here
                if (hit) begin
                    state_d = IDLE;
                end else begin
                    state_d = MISS;
                end
            end
            MISS: begin
                if (mem_ready_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // the refilled line hits on the next lookup
                state_d = LOOKUP;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (flush_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request address is taken only while idle
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && cpu_req_valid_i) begin
            addr_q <= cpu_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == MISS) && mem_ready_i) begin
            refill_q <= mem_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (line_wr) begin
            data_mem[addr_idx] <= refill_q;
            tag_mem[addr_idx]  <= addr_tag;
        end
    end

    // flush wins over a line being written in the same cycle
    always_ff @(posedge clk) begin
        if (flush_i) begin
            valid_q <= '0;
        end else if (line_wr) begin
            valid_q[addr_idx] <= 1'b1;
        end
    end

    // upper or lower word of the line
    assign cpu_rdata_o = addr_q[WORD_SEL_BIT] ? line_rd[LINE_BITS-1 -: WORD_BITS]
                                              : line_rd[WORD_BITS-1:0];

    assign cpu_ready_o  = (state_q == LOOKUP) && hit;
    assign cache_idle_o = (state_q == IDLE);

    // held from the missing lookup until memory answers
    assign mem_valid_o = ((state_q == LOOKUP) && !hit) || (state_q == MISS);
    assign mem_addr_o  = {addr_q[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

endmodule

/* source/ifu.sv */
/*
 * instruction fetch unit
 * pc register, cache request sequencing, instruction select and hold for decode
 */
`timescale 1ns/1ps

module ifu
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fence_i,

    // core side
    input  logic                 dnpc_valid_i,
    input  logic                 block_i,
    input  logic [XLEN-1:0]      dnpc_i,
    input  logic                 id_en_i,
    output logic [XLEN-1:0]      pc_o,
    output logic [ILEN-1:0]      instr_o,
    output logic                 if_busy_o,

    // cache side
    output logic [XLEN-1:0]      cpu_addr_o,
    output logic                 cpu_req_valid_o,
    input  logic [WORD_BITS-1:0] cpu_rdata_i,
    input  logic                 cpu_ready_i,
    input  logic                 cache_idle_i,
    output logic                 flush_o
);

    logic [XLEN-1:0] pc_q;

    // first cycle out of reset
    logic start_q;

    // request accepted by the cache, answer not back yet
    logic pending_q;

    // instruction returned but not yet taken by decode
    logic held_q;

    logic [ILEN-1:0] hold_q;
    logic [ILEN-1:0] instr_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (dnpc_valid_i && !block_i) begin
            pc_q <= dnpc_i;
        end
    end

    always_ff @(posedge clk) begin
        start_q <= rst;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (cpu_ready_i) begin
            pending_q <= 1'b0;
        end else if (cpu_req_valid_o && cache_idle_i) begin
            pending_q <= 1'b1;
        end
    end

    // decode taking the instruction releases the hold
    always_ff @(posedge clk) begin
        if (rst || id_en_i) begin
            held_q <= 1'b0;
        end else if (cpu_ready_i) begin
            held_q <= 1'b1;
        end
    end

    // 32-bit half of the returned word
    assign instr_sel = pc_q[INSTR_SEL_BIT] ? cpu_rdata_i[WORD_BITS-1 -: ILEN]
                                           : cpu_rdata_i[ILEN-1:0];

    always_ff @(posedge clk) begin
        if (cpu_ready_i) begin
            hold_q <= instr_sel;
        end
    end

    // no new request while one is in flight, being answered or held
    assign cpu_req_valid_o = start_q || (!pending_q && !cpu_ready_i && !held_q);

    assign if_busy_o = !cpu_ready_i && !held_q;
    assign instr_o   = held_q ? hold_q : instr_sel;

    assign pc_o       = pc_q;
    assign cpu_addr_o = pc_q;

    // reset and fence.i both invalidate the cache
    assign flush_o = rst || fence_i;

endmodule

/* source/fetch_top.sv */
/*
 * fetch stage top
 * fetch unit and instruction cache, with core-side and memory-side ports
 */
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fence_i,

    // core side
    input  logic                 dnpc_valid_i,
    input  logic                 block_i,
    input  logic [XLEN-1:0]      dnpc_i,
    input  logic                 id_en_i,
    output logic [XLEN-1:0]      pc_o,
    output logic [ILEN-1:0]      instr_o,
    output logic                 if_busy_o,

    // memory side
    output logic [XLEN-1:0]      mem_addr_o,
    output logic                 mem_valid_o,
    input  logic [LINE_BITS-1:0] mem_rdata_i,
    input  logic                 mem_ready_i
);

    logic [XLEN-1:0]      cpu_addr;
    logic                 cpu_req_valid;
    logic [WORD_BITS-1:0] cpu_rdata;
    logic                 cpu_ready;
    logic                 cache_idle;
    logic                 flush;

    ifu u_ifu (
        .clk             (clk),
        .rst             (rst),
        .fence_i         (fence_i),
        .dnpc_valid_i    (dnpc_valid_i),
        .block_i         (block_i),
        .dnpc_i          (dnpc_i),
        .id_en_i         (id_en_i),
        .pc_o            (pc_o),
        .instr_o         (instr_o),
        .if_busy_o       (if_busy_o),
        .cpu_addr_o      (cpu_addr),
        .cpu_req_valid_o (cpu_req_valid),
        .cpu_rdata_i     (cpu_rdata),
        .cpu_ready_i     (cpu_ready),
        .cache_idle_i    (cache_idle),
        .flush_o         (flush)
    );

    icache u_icache (
        .clk             (clk),
        .flush_i         (flush),
        .cpu_addr_i      (cpu_addr),
        .cpu_req_valid_i (cpu_req_valid),
        .cpu_rdata_o     (cpu_rdata),
        .cpu_ready_o     (cpu_ready),
        .cache_idle_o    (cache_idle),
        .mem_addr_o      (mem_addr_o),
        .mem_valid_o     (mem_valid_o),
        .mem_rdata_i     (mem_rdata_i),
        .mem_ready_i     (mem_ready_i)
    );

endmodule

/* testbench/fetch_tb_ref.svh */
/*
 * fetch testbench reference
 * memory line contents per line address and generation, plus the xorshift step
 */

// every 32-bit slot mixes the whole line address with the generation
function automatic logic [LINE_BITS-1:0] mem_line(input logic [XLEN-1:0] addr,
                                                  input logic [31:0] gen);
    logic [LINE_BITS-1:0] line;
    logic [XLEN-1:0]      base;
    logic [31:0]          word_addr;
    int                   k;
    base = {addr[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    for (k = 0; k < 4; k++) begin
        word_addr = base[31:0] + (k * 4);
        line[k*32 +: 32] = ((word_addr ^ base[63:32]) * 32'h9e37_79b1)
                           ^ (gen * 32'h7f4a_7c15) ^ base[47:16];
    end
    return line;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

/* testbench/fetch_mem_model.sv */
/*
 * memory model for the fetch testbench
 * answers each line request after a random delay of 1 to 6 cycles
 */
`timescale 1ns/1ps

module fetch_mem_model
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [XLEN-1:0]      mem_addr_i,
    input  logic                 mem_valid_i,
    input  logic [31:0]          gen_i,
    output logic [LINE_BITS-1:0] mem_rdata_o,
    output logic                 mem_ready_o
);

    `include "fetch_tb_ref.svh"

    logic [31:0] rng_q = 32'd94;
    logic        busy_q;
    logic [2:0]  wait_q;

    always @(posedge clk) begin
        if (rst) begin
            busy_q      <= 1'b0;
            mem_ready_o <= 1'b0;
        end else begin
            mem_ready_o <= 1'b0;
            if (busy_q) begin
                if (wait_q == 3'd0) begin
                    mem_ready_o <= 1'b1;
                    mem_rdata_o <= mem_line(mem_addr_i, gen_i);
                    busy_q      <= 1'b0;
                end else begin
                    wait_q <= wait_q - 3'd1;
                end
            end else if (mem_valid_i && !mem_ready_o) begin
                // valid is still high in the pulse cycle, so skip that one
                busy_q <= 1'b1;
                wait_q <= 3'(rng_q % 6);
                rng_q  <= xorshift32(rng_q);
            end
        end
    end

endmodule

/* testbench/fetch_tb.sv */
/*
 * fetch stage testbench
 * drives fetch_top through reset, sequential, jump, back-pressure and fence.i
 * fetches, and compares every presented instruction with the memory reference
 */
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
;

    `include "fetch_tb_ref.svh"

    localparam int SEQ_STEPS      = 12;
    localparam int NUM_JUMP       = 16;
    localparam int NUM_STALL      = 8;
    localparam int NUM_FENCE      = 6;
    localparam int NUM_FETCHES    = SEQ_STEPS + NUM_JUMP + NUM_STALL + NUM_FENCE + 1;
    localparam int TIMEOUT_CYCLES = 40 * NUM_FETCHES;

    logic                 clk;
    logic                 rst;
    logic                 fence_i;
    logic                 dnpc_valid_i;
    logic                 block_i;
    logic [XLEN-1:0]      dnpc_i;
    logic                 id_en_i;
    logic [XLEN-1:0]      pc_o;
    logic [ILEN-1:0]      instr_o;
    logic                 if_busy_o;
    logic [XLEN-1:0]      mem_addr_o;
    logic                 mem_valid_o;
    logic [LINE_BITS-1:0] mem_rdata_i;
    logic                 mem_ready_i;

    logic [31:0]     gen;
    logic [31:0]     rng;
    logic [31:0]     rnd;
    logic [XLEN-1:0] expected_pc;
    logic [XLEN-1:0] jump_addr;
    string           test_name;
    int              cycles = 0;
    int              i;

    fetch_top DUT (
        .clk          (clk),
        .rst          (rst),
        .fence_i      (fence_i),
        .dnpc_valid_i (dnpc_valid_i),
        .block_i      (block_i),
        .dnpc_i       (dnpc_i),
        .id_en_i      (id_en_i),
        .pc_o         (pc_o),
        .instr_o      (instr_o),
        .if_busy_o    (if_busy_o),
        .mem_addr_o   (mem_addr_o),
        .mem_valid_o  (mem_valid_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ready_i  (mem_ready_i)
    );

    fetch_mem_model u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_addr_i  (mem_addr_o),
        .mem_valid_i (mem_valid_o),
        .gen_i       (gen),
        .mem_rdata_o (mem_rdata_i),
        .mem_ready_o (mem_ready_i)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // instruction at pc in the memory image of generation g
    function automatic logic [ILEN-1:0] expected_instr(input logic [XLEN-1:0] pc,
                                                       input logic [31:0] g);
        logic [LINE_BITS-1:0] line;
        line = mem_line(pc, g);
        return line[pc[3:2] * ILEN +: ILEN];
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Error: %s %s expected %h actual %h", name, what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // any revisit lands in the three lines fetched sequentially
    function automatic logic [XLEN-1:0] revisit_addr(input logic [31:0] r);
        return RESET_PC + (((r >> 8) % SEQ_STEPS) * 4);
    endfunction

    task automatic wait_presented();
        @(posedge clk);
        while (if_busy_o !== 1'b0) begin
            @(posedge clk);
        end
    endtask

    // wait for the instruction, optionally stall and fence, then take it
    task automatic fetch_step(input logic [XLEN-1:0] next_pc, input logic blk,
                              input int stall, input logic fence);
        int n;
        wait_presented();
        check_value(test_name, "pc", expected_pc, pc_o);
        for (n = 0; n < stall; n++) begin
            @(posedge clk);
            check_value(test_name, "mem_valid", 64'd0, {63'd0, mem_valid_o});
            check_value(test_name, "if_busy", 64'd0, {63'd0, if_busy_o});
        end
        if (fence) begin
            fence_i <= 1'b1;
            @(posedge clk);
            fence_i <= 1'b0;
        end
        id_en_i      <= 1'b1;
        dnpc_valid_i <= 1'b1;
        dnpc_i       <= next_pc;
        block_i      <= blk;
        @(posedge clk);
        id_en_i      <= 1'b0;
        dnpc_valid_i <= 1'b0;
        block_i      <= 1'b0;
        // the held instruction is still compared at this edge with the old image
        if (fence) begin
            gen <= gen + 1;
        end
        if (!blk) begin
            expected_pc = next_pc;
        end
    endtask

    // compare every presented instruction
    always @(posedge clk) begin
        if (!rst && (if_busy_o === 1'b0)) begin
            check_value(test_name, "instr", {32'd0, expected_instr(pc_o, gen)}, {32'd0, instr_o});
        end
        // a refill asks for the aligned line holding the pc
        if (!rst && (mem_valid_o === 1'b1)) begin
            check_value(test_name, "mem_addr", {pc_o[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}},
                        mem_addr_o);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, fetch did not finish", cycles);
            $display("Result: FAILED");
            $fatal(1, "run stopped");
        end
    end

    initial begin
        rst          = 1'b1;
        fence_i      = 1'b0;
        dnpc_valid_i = 1'b0;
        block_i      = 1'b0;
        dnpc_i       = '0;
        id_en_i      = 1'b0;
        gen          = 32'd0;
        rng          = 32'd94;
        expected_pc  = RESET_PC;
        test_name    = "reset";
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        fetch_step(RESET_PC + 4, 1'b0, 0, 1'b0);

        test_name = "sequential";
        for (i = 1; i < SEQ_STEPS; i++) begin
            fetch_step(RESET_PC + 4 * (i + 1), 1'b0, 0, 1'b0);
        end

        // new addresses span 4 KB, so some evict lines of the same index
        test_name = "jump";
        for (i = 0; i < NUM_JUMP; i++) begin
            rng = xorshift32(rng);
            rnd = rng;
            if (rnd[0]) begin
                jump_addr = revisit_addr(rnd);
            end else begin
                jump_addr = RESET_PC + {rnd[13:4], 2'b00};
            end
            fetch_step(jump_addr, rnd[1] & rnd[2], 0, 1'b0);
        end

        test_name = "backpressure";
        for (i = 0; i < NUM_STALL; i++) begin
            rng = xorshift32(rng);
            fetch_step(expected_pc + 4, 1'b0, 1 + (rng % 8), 1'b0);
        end

        test_name = "fence";
        for (i = 0; i < NUM_FENCE; i++) begin
            rng = xorshift32(rng);
            fetch_step(revisit_addr(rng), 1'b0, 0, (i % 2) == 0);
        end

        wait_presented();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* build.f */
+incdir+testbench
source/fetch_pkg.sv
source/icache.sv
source/ifu.sv
source/fetch_top.sv
testbench/fetch_mem_model.sv
testbench/fetch_tb.sv
